//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --timescale 1ns/1ps -Wno-fatal
TOP      = usb_reg_tb
FILELIST = usb_reg_top.f
OBJ_DIR  = obj_dir

.PHONY: sim clean

# build, run, and pass only when the pass message shows up
sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "Everything OK"

clean:
	rm -rf $(OBJ_DIR)

//--- bench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
   parameter int PERIOD_NS    = 4,
   parameter int RESET_CYCLES = 3
) (
   output logic clk_usb,
   output logic reset
);

   initial begin
      clk_usb = 1'b0;
      forever #(PERIOD_NS / 2) clk_usb = ~clk_usb;
   end

   // sync reset, released on a falling edge
   initial begin
      reset = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk_usb);
      @(negedge clk_usb);
      reset <= 1'b0;
   end

endmodule

//--- bench/usb_reg_tb.sv
`timescale 1ns/1ps

module usb_reg_tb;

   localparam int CLK_PERIOD_NS = 4;
   localparam int IDLE_CYCLES   = 3;                       // gap between accesses
   localparam int BURST_LEN     = 10;                      // below fifo depth
   localparam int OVF_LEN       = reg_map_pkg::FIFO_DEPTH + 4;
   // every bus access and stream byte plus slack for the idle checks
   localparam int NUM_ACCESSES  = 5 + 12 + 4 + (2 * BURST_LEN + 4) +
                                  (OVF_LEN + reg_map_pkg::FIFO_DEPTH + 5) + 6 + 4;
   localparam int MARGIN_NS     = 400;

   logic                   clk_usb;
   logic                   reset;
   usb_bus_pkg::byte_t     cwusb_din;
   usb_bus_pkg::byte_t     cwusb_dout;
   logic                   cwusb_isout;
   usb_bus_pkg::bus_addr_t cwusb_addr;
   logic                   cwusb_rdn;
   logic                   cwusb_wrn;
   logic                   cwusb_cen;
   logic                   cwusb_alen;
   usb_bus_pkg::byte_t     stream_data;
   logic                   stream_strobe;

   // reference model state
   usb_bus_pkg::word_t     model_scratch;
   usb_bus_pkg::byte_t     model_control;
   usb_bus_pkg::byte_t     model_fifo[$];
   logic                   model_overflow;
   usb_bus_pkg::bus_addr_t cur_addr;
   int                     model_cnt;      // byte position since address phase
   int                     seed;

   tb_clock #(.PERIOD_NS(CLK_PERIOD_NS), .RESET_CYCLES(3)) u_clock (
      .clk_usb (clk_usb),
      .reset   (reset)
   );

   usb_reg_top uut (
      .clk_usb       (clk_usb),
      .reset         (reset),
      .cwusb_din     (cwusb_din),
      .cwusb_dout    (cwusb_dout),
      .cwusb_isout   (cwusb_isout),
      .cwusb_addr    (cwusb_addr),
      .cwusb_rdn     (cwusb_rdn),
      .cwusb_wrn     (cwusb_wrn),
      .cwusb_cen     (cwusb_cen),
      .cwusb_alen    (cwusb_alen),
      .stream_data   (stream_data),
      .stream_strobe (stream_strobe)
   );

   ////////////////////////////////////////////////////////////
   // reference model
   ////////////////////////////////////////////////////////////

   function automatic usb_bus_pkg::byte_t expected_byte(usb_bus_pkg::bus_addr_t addr, int cnt);
      usb_bus_pkg::word_t       word;
      usb_bus_pkg::byte_t       result;
      reg_map_pkg::fifo_count_t level;
      word   = '0;
      result = '0;
      level  = reg_map_pkg::fifo_count_t'(model_fifo.size());
      case (addr)
         reg_map_pkg::ADDR_ID:      word = reg_map_pkg::ID_VALUE;
         reg_map_pkg::ADDR_SCRATCH: word = model_scratch;
         reg_map_pkg::ADDR_CONTROL: word[7:0] = model_control;   // upper lanes zero
         reg_map_pkg::ADDR_FIFO_DATA: begin
            if (model_fifo.size() > 0) result = model_fifo[0];    // empty gives 0
         end
         reg_map_pkg::ADDR_FIFO_STATUS: begin
            result[reg_map_pkg::FIFO_PTR_W:0]     = level;
            result[reg_map_pkg::STATUS_OVERFLOW] = model_overflow;
         end
         default: ;
      endcase
      if (addr < reg_map_pkg::ADDR_FIFO_DATA) begin
         word   = word >> ((cnt % 4) * 8);     // lane from low count bits
         result = word[7:0];
      end
      return result;
   endfunction

   function automatic usb_bus_pkg::byte_t random_byte();
      int r;
      r = $random(seed);
      return r[7:0];
   endfunction

   ////////////////////////////////////////////////////////////
   // compare tasks
   ////////////////////////////////////////////////////////////

   task automatic compare_byte(input string name, input usb_bus_pkg::byte_t exp,
                               input usb_bus_pkg::byte_t act);
      if (act !== exp) begin
         $display("ERROR %s expected 0x%02h actual 0x%02h", name, exp, act);
         $display("Something failed");
         $fatal(1, "stopped at first mismatch");
      end
   endtask

   task automatic compare_count(input string name, input reg_map_pkg::fifo_count_t exp,
                                input reg_map_pkg::fifo_count_t act);
      if (act !== exp) begin
         $display("ERROR %s expected %0d actual %0d", name, exp, act);
         $display("Something failed");
         $fatal(1, "stopped at first mismatch");
      end
   endtask

   task automatic compare_flag(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("ERROR %s expected %b actual %b", name, exp, act);
         $display("Something failed");
         $fatal(1, "stopped at first mismatch");
      end
   endtask

   ////////////////////////////////////////////////////////////
   // host bus tasks start and end on a falling edge
   ////////////////////////////////////////////////////////////

   task automatic idle(input int n);
      repeat (n) @(negedge clk_usb);
   endtask

   task automatic set_address(input usb_bus_pkg::bus_addr_t addr);
      cwusb_addr = addr;
      cwusb_alen = 1'b0;     // address phase
      @(negedge clk_usb);
      cwusb_alen = 1'b1;
      cur_addr   = addr;
      model_cnt  = 0;        // count restarts at lane 0
      idle(IDLE_CYCLES);
   endtask

   task automatic bus_write(input string name, input usb_bus_pkg::byte_t data);
      cwusb_din = data;
      cwusb_cen = 1'b0;
      cwusb_wrn = 1'b0;
      idle(3);
      compare_flag({name, " isout"}, 1'b0, cwusb_isout);   // host owns the bus
      @(negedge clk_usb);
      cwusb_wrn = 1'b1;
      cwusb_cen = 1'b1;
      case (cur_addr)
         reg_map_pkg::ADDR_SCRATCH: model_scratch[(model_cnt % 4) * 8 +: 8] = data;
         reg_map_pkg::ADDR_CONTROL: if (model_cnt % 4 == 0) model_control = data;
         default: ;                                        // id is read only
      endcase
      model_cnt++;
      idle(IDLE_CYCLES);
   endtask

   task automatic read_check(input string name, output usb_bus_pkg::byte_t act);
      usb_bus_pkg::byte_t exp;
      exp       = expected_byte(cur_addr, model_cnt);
      cwusb_cen = 1'b0;
      cwusb_rdn = 1'b0;
      idle(3);
      act = cwusb_dout;                                     // last low cycle
      compare_byte(name, exp, act);
      compare_flag({name, " isout"}, 1'b1, cwusb_isout);
      @(negedge clk_usb);
      cwusb_rdn = 1'b1;
      cwusb_cen = 1'b1;
      // end of read pops data or clears the sticky flag
      if (cur_addr == reg_map_pkg::ADDR_FIFO_DATA && model_fifo.size() > 0) begin
         void'(model_fifo.pop_front());
      end
      if (cur_addr == reg_map_pkg::ADDR_FIFO_STATUS) model_overflow = 1'b0;
      model_cnt++;
      idle(IDLE_CYCLES);
   endtask

   // one byte per cycle with no back-pressure
   task automatic push_stream(input int n);
      repeat (n) begin
         stream_data   = random_byte();
         stream_strobe = 1'b1;
         if (model_fifo.size() < reg_map_pkg::FIFO_DEPTH) model_fifo.push_back(stream_data);
         else model_overflow = 1'b1;                        // dropped
         @(negedge clk_usb);
      end
      stream_strobe = 1'b0;
      idle(IDLE_CYCLES);
   endtask

   ////////////////////////////////////////////////////////////
   // watchdog
   ////////////////////////////////////////////////////////////

   initial begin
      #(NUM_ACCESSES * 20 * CLK_PERIOD_NS + MARGIN_NS);
      $display("watchdog expired, the run hung before all tests finished");
      $display("Something failed");
      $fatal(1, "timeout");
   end

   ////////////////////////////////////////////////////////////
   // test sequence and checks
   ////////////////////////////////////////////////////////////

   initial begin : main
      usb_bus_pkg::byte_t       data;
      usb_bus_pkg::byte_t       act;
      reg_map_pkg::fifo_count_t level;
      cwusb_din      = '0;
      cwusb_addr     = '0;
      cwusb_rdn      = 1'b1;      // strobes idle high
      cwusb_wrn      = 1'b1;
      cwusb_cen      = 1'b1;
      cwusb_alen     = 1'b1;
      stream_data    = '0;
      stream_strobe  = 1'b0;
      model_scratch  = '0;
      model_control  = '0;
      model_overflow = 1'b0;
      cur_addr       = '0;
      model_cnt      = 0;
      seed           = 72303;
      @(negedge clk_usb);
      while (reset) @(negedge clk_usb);
      idle(2);
      compare_flag("isout after reset", 1'b0, cwusb_isout);

      // id word in lane order
      set_address(reg_map_pkg::ADDR_ID);
      for (int i = 0; i < 4; i++) read_check($sformatf("id lane %0d", i), act);

      // scratch write then fresh address phase
      set_address(reg_map_pkg::ADDR_SCRATCH);
      for (int i = 0; i < 4; i++) bus_write($sformatf("scratch write %0d", i), random_byte());
      // partial read leaves the count off lane 0
      set_address(reg_map_pkg::ADDR_SCRATCH);
      read_check("scratch partial", act);
      set_address(reg_map_pkg::ADDR_SCRATCH);
      for (int i = 0; i < 4; i++) read_check($sformatf("scratch lane %0d", i), act);

      // control byte with fast mode kept off
      data = random_byte();
      data[reg_map_pkg::CTRL_FAST_READ] = 1'b0;
      set_address(reg_map_pkg::ADDR_CONTROL);
      bus_write("control write", data);
      set_address(reg_map_pkg::ADDR_CONTROL);
      read_check("control read", act);

      // fifo order and empty read
      push_stream(BURST_LEN);
      set_address(reg_map_pkg::ADDR_FIFO_STATUS);
      read_check("burst status", act);
      level = act[reg_map_pkg::FIFO_PTR_W:0];
      compare_count("burst count", reg_map_pkg::fifo_count_t'(BURST_LEN), level);
      set_address(reg_map_pkg::ADDR_FIFO_DATA);
      for (int i = 0; i <= BURST_LEN; i++) read_check($sformatf("fifo byte %0d", i), act);

      // overflow stays sticky until status read
      push_stream(OVF_LEN);
      set_address(reg_map_pkg::ADDR_FIFO_STATUS);
      read_check("overflow status", act);
      level = act[reg_map_pkg::FIFO_PTR_W:0];
      compare_count("full count", reg_map_pkg::fifo_count_t'(reg_map_pkg::FIFO_DEPTH), level);
      compare_flag("overflow set", 1'b1, act[reg_map_pkg::STATUS_OVERFLOW]);
      read_check("status after clear", act);
      compare_flag("overflow cleared", 1'b0, act[reg_map_pkg::STATUS_OVERFLOW]);
      set_address(reg_map_pkg::ADDR_FIFO_DATA);
      for (int i = 0; i <= reg_map_pkg::FIFO_DEPTH; i++) begin
         read_check($sformatf("overflow byte %0d", i), act);
      end

      // fast mode holds the bus until the next write
      data = '0;
      data[reg_map_pkg::CTRL_FAST_READ] = 1'b1;
      set_address(reg_map_pkg::ADDR_CONTROL);
      bus_write("fast enable", data);
      idle(2);
      for (int i = 0; i < 4; i++) begin
         compare_flag($sformatf("fast idle isout %0d", i), 1'b1, cwusb_isout);
         @(negedge clk_usb);
      end
      set_address(reg_map_pkg::ADDR_CONTROL);
      read_check("fast control read", act);
      compare_flag("isout after fast read", 1'b1, cwusb_isout);
      set_address(reg_map_pkg::ADDR_CONTROL);
      bus_write("fast disable", 8'h00);
      compare_flag("isout after write", 1'b0, cwusb_isout);

      $display("Everything OK");
      $finish;
   end

endmodule

//--- logic/reg_control.sv
`timescale 1ns/1ps

module reg_control (
   input  logic                   clk_usb,
   input  logic                   reset,
   input  usb_bus_pkg::bus_addr_t reg_address,
   input  usb_bus_pkg::bytecnt_t  reg_bytecnt,
   input  usb_bus_pkg::byte_t     reg_datao,
   input  logic                   reg_write,
   output usb_bus_pkg::word_t     ctrl_word,       // addressed register, 0 if none
   output logic                   fast_fifo_read
);

   usb_bus_pkg::word_t scratch;
   usb_bus_pkg::byte_t control;
   usb_bus_pkg::lane_t lane;

   // only low count bits select the byte within a word
   assign lane = reg_bytecnt[usb_bus_pkg::LANE_W-1:0];

   ////////////////////////////////////////////////////////////
   // register writes
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         scratch <= '0;
         control <= '0;
      end else if (reg_write) begin
         case (reg_address)
            reg_map_pkg::ADDR_SCRATCH: begin
               // one lane per write, count walks through the word
               scratch[lane*usb_bus_pkg::BYTE_W +: usb_bus_pkg::BYTE_W] <= reg_datao;
            end
            reg_map_pkg::ADDR_CONTROL: begin
               if (lane == '0) begin
                  control <= reg_datao;   // single byte register
               end
            end
            default: ;                    // id and foreign addresses ignored
         endcase
      end
   end

   ////////////////////////////////////////////////////////////
   // read side
   ////////////////////////////////////////////////////////////

   always_comb begin
      case (reg_address)
         reg_map_pkg::ADDR_ID:      ctrl_word = reg_map_pkg::ID_VALUE;
         reg_map_pkg::ADDR_SCRATCH: ctrl_word = scratch;
         reg_map_pkg::ADDR_CONTROL: ctrl_word = usb_bus_pkg::word_t'(control);  // zero ext
         default:                   ctrl_word = '0;
      endcase
   end

   // back to the bridge, changes read strobe timing
   assign fast_fifo_read = control[reg_map_pkg::CTRL_FAST_READ];

endmodule

//--- logic/reg_fifo.sv
`timescale 1ns/1ps

module reg_fifo (
   input  logic                   clk_usb,
   input  logic                   reset,
   input  usb_bus_pkg::byte_t     stream_data,
   input  logic                   stream_strobe,    // no back-pressure
   input  usb_bus_pkg::bus_addr_t reg_address,
   input  logic                   reg_read,
   output usb_bus_pkg::byte_t     fifo_byte
);

   usb_bus_pkg::byte_t             mem [reg_map_pkg::FIFO_DEPTH];
   logic [reg_map_pkg::FIFO_PTR_W-1:0] wr_ptr;
   logic [reg_map_pkg::FIFO_PTR_W-1:0] rd_ptr;
   reg_map_pkg::fifo_count_t       count;
   logic                           overflow;   // sticky until status read
   logic                           reg_read_r;
   logic                           read_end;
   logic                           empty;
   logic                           full;
   logic                           push;
   logic                           pop;

   assign empty    = (count == '0);
   assign full     = (count == reg_map_pkg::fifo_count_t'(reg_map_pkg::FIFO_DEPTH));
   assign read_end = reg_read_r & ~reg_read;    // falling edge of read level
   assign push     = stream_strobe & ~full;     // full drops the byte
   assign pop      = read_end & (reg_address == reg_map_pkg::ADDR_FIFO_DATA) & ~empty;

   ////////////////////////////////////////////////////////////
   // storage
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk_usb) begin
      if (push) begin
         mem[wr_ptr] <= stream_data;
      end
   end

   ////////////////////////////////////////////////////////////
   // pointers, count, overflow
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         wr_ptr     <= '0;
         rd_ptr     <= '0;
         count      <= '0;
         overflow   <= 1'b0;
         reg_read_r <= 1'b0;
      end else begin
         reg_read_r <= reg_read;
         if (push) wr_ptr <= wr_ptr + 1'b1;     // depth is a power of two
         if (pop) rd_ptr <= rd_ptr + 1'b1;
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: ;                          // both or neither
         endcase
         // a new drop beats a clearing status read
         if (stream_strobe && full) begin
            overflow <= 1'b1;
         end else if (read_end && (reg_address == reg_map_pkg::ADDR_FIFO_STATUS)) begin
            overflow <= 1'b0;
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // read side
   ////////////////////////////////////////////////////////////

   always_comb begin
      fifo_byte = '0;
      case (reg_address)
         reg_map_pkg::ADDR_FIFO_DATA: begin
            if (!empty) fifo_byte = mem[rd_ptr];  // head, 0 when drained
         end
         reg_map_pkg::ADDR_FIFO_STATUS: begin
            fifo_byte[reg_map_pkg::FIFO_PTR_W:0]     = count;
            fifo_byte[reg_map_pkg::STATUS_OVERFLOW] = overflow;
         end
         default: ;
      endcase
   end

endmodule

//--- logic/reg_map_pkg.sv
package reg_map_pkg;

   ////////////////////////////////////////////////////////////
   // register addresses
   ////////////////////////////////////////////////////////////

   // control side, everything below the fifo block
   localparam usb_bus_pkg::bus_addr_t ADDR_ID          = 8'h00;   // read only
   localparam usb_bus_pkg::bus_addr_t ADDR_SCRATCH     = 8'h01;   // 32 bit r/w
   localparam usb_bus_pkg::bus_addr_t ADDR_CONTROL     = 8'h02;   // one byte

   // stream fifo block
   localparam usb_bus_pkg::bus_addr_t ADDR_FIFO_DATA   = 8'h10;   // pops on read end
   localparam usb_bus_pkg::bus_addr_t ADDR_FIFO_STATUS = 8'h11;   // count + overflow

   // identification word, returned lane 0 first
   localparam usb_bus_pkg::word_t ID_VALUE = 32'hCB15_0A01;

   ////////////////////////////////////////////////////////////
   // fifo geometry
   ////////////////////////////////////////////////////////////

   localparam int FIFO_DEPTH = 16;
   localparam int FIFO_PTR_W = 4;

   // one extra bit so a full fifo is distinct from empty
   typedef logic [FIFO_PTR_W:0] fifo_count_t;

   // bit positions
   localparam int CTRL_FAST_READ  = 1;   // control byte, fast fifo read mode
   localparam int STATUS_OVERFLOW = 7;   // status byte, sticky overflow

endpackage

//--- logic/reg_read_mux.sv
`timescale 1ns/1ps

module reg_read_mux (
   input  usb_bus_pkg::bus_addr_t reg_address,
   input  usb_bus_pkg::bytecnt_t  reg_bytecnt,
   input  usb_bus_pkg::word_t     ctrl_word,
   input  usb_bus_pkg::byte_t     fifo_byte,
   output usb_bus_pkg::byte_t     reg_datai
);

   usb_bus_pkg::lane_t lane;

   // wraps every four bytes, so long reads repeat the word
   assign lane = reg_bytecnt[usb_bus_pkg::LANE_W-1:0];

   ////////////////////////////////////////////////////////////
   // source and lane select
   ////////////////////////////////////////////////////////////

   always_comb begin
      if (reg_address < reg_map_pkg::ADDR_FIFO_DATA) begin
         // control block space, word wide registers
         reg_datai = ctrl_word[lane*usb_bus_pkg::BYTE_W +: usb_bus_pkg::BYTE_W];
      end else if ((reg_address == reg_map_pkg::ADDR_FIFO_DATA) ||
                   (reg_address == reg_map_pkg::ADDR_FIFO_STATUS)) begin
         reg_datai = fifo_byte;   // already a single byte
      end else begin
         reg_datai = '0;          // unmapped
      end
   end

endmodule

//--- logic/usb_bus_pkg.sv
package usb_bus_pkg;

   ////////////////////////////////////////////////////////////
   // host bus widths
   ////////////////////////////////////////////////////////////

   localparam int BYTE_W    = 8;    // data bus and register byte
   localparam int ADDR_W    = 8;    // host register address
   localparam int WORD_W    = 32;   // widest register
   localparam int BYTECNT_W = 7;    // byte position, free running
   localparam int LANE_W    = 2;    // low count bits pick a lane of a word

   ////////////////////////////////////////////////////////////
   // vector types
   ////////////////////////////////////////////////////////////

   typedef logic [BYTE_W-1:0]    byte_t;
   typedef logic [ADDR_W-1:0]    bus_addr_t;
   typedef logic [BYTECNT_W-1:0] bytecnt_t;    // rolls over, only lanes matter
   typedef logic [WORD_W-1:0]    word_t;

   // lane index within a word
   typedef logic [LANE_W-1:0]    lane_t;

endpackage

//--- logic/usb_reg_main.sv
`timescale 1ns/1ps

module usb_reg_main (
   input  logic                   clk_usb,
   input  logic                   reset,

   // host side, async memory bus
   input  usb_bus_pkg::byte_t     cwusb_din,
   output usb_bus_pkg::byte_t     cwusb_dout,
   output logic                   cwusb_isout,    // fpga drives data bus
   input  usb_bus_pkg::bus_addr_t cwusb_addr,
   input  logic                   cwusb_rdn,
   input  logic                   cwusb_wrn,
   input  logic                   cwusb_cen,
   input  logic                   cwusb_alen,

   // register side
   input  logic                   fast_fifo_read,
   output usb_bus_pkg::bus_addr_t reg_address,
   output usb_bus_pkg::bytecnt_t  reg_bytecnt,
   output usb_bus_pkg::byte_t     reg_datao,
   input  usb_bus_pkg::byte_t     reg_datai,
   output logic                   reg_read,       // level, whole read access
   output logic                   reg_write       // one cycle pulse
);

   logic wrn_rs;           // wrn sampled once
   logic wrn_rs_dly;       // wrn sampled twice
   logic reg_write_dly;    // bumps the byte count
   logic rd_active;        // rdn low, one cycle late
   logic rd_active_dly;    // held one more cycle for isout tail
   logic alen_r;
   logic fast_read_r;      // edge detect on fast mode enable
   logic drive_data_out;   // bus held by fast mode until next write

   ////////////////////////////////////////////////////////////
   // strobe sampling
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         wrn_rs        <= 1'b1;   // bus idles high
         wrn_rs_dly    <= 1'b1;
         reg_write     <= 1'b0;
         reg_write_dly <= 1'b0;
         rd_active     <= 1'b0;
         rd_active_dly <= 1'b0;
         alen_r        <= 1'b1;
      end else begin
         wrn_rs        <= cwusb_wrn;
         wrn_rs_dly    <= wrn_rs;
         // rising edge of synced wrn marks end of write
         reg_write     <= wrn_rs & ~wrn_rs_dly;
         reg_write_dly <= reg_write;
         rd_active     <= ~cwusb_rdn;
         rd_active_dly <= rd_active;
         alen_r        <= cwusb_alen;
      end
   end

   // fast mode skips the sync cycle on reads
   assign reg_read = fast_fifo_read ? ~cwusb_rdn : rd_active;

   ////////////////////////////////////////////////////////////
   // address and write data
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk_usb) begin
      reg_address <= cwusb_addr;                  // one cycle behind the bus
      if (~cwusb_cen && ~wrn_rs) begin
         reg_datao <= cwusb_din;                  // last sample before wrn rises wins
      end
   end

   // read data straight through, mux is combinational
   assign cwusb_dout = reg_datai;

   ////////////////////////////////////////////////////////////
   // byte count
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         reg_bytecnt <= '0;
      end else if (~alen_r) begin
         reg_bytecnt <= '0;                       // new address phase
      end else if ((rd_active_dly && ~rd_active) || reg_write_dly) begin
         reg_bytecnt <= reg_bytecnt + 1'b1;       // wraps freely
      end
   end

   ////////////////////////////////////////////////////////////
   // data bus drive
   ////////////////////////////////////////////////////////////

   // fast mode grabs the bus on enable and lets go when a write starts
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         fast_read_r    <= 1'b0;
         drive_data_out <= 1'b0;
      end else begin
         fast_read_r <= fast_fifo_read;
         if (~cwusb_wrn) begin
            drive_data_out <= 1'b0;
         end else if (fast_fifo_read && ~fast_read_r) begin
            drive_data_out <= 1'b1;
         end
      end
   end

   // keep driving a cycle past the read so the host never sees a float
   assign cwusb_isout = rd_active | rd_active_dly | (drive_data_out & cwusb_wrn);

endmodule

//--- logic/usb_reg_top.sv
`timescale 1ns/1ps

module usb_reg_top (
   input  logic                   clk_usb,
   input  logic                   reset,

   // host bus
   input  usb_bus_pkg::byte_t     cwusb_din,
   output usb_bus_pkg::byte_t     cwusb_dout,
   output logic                   cwusb_isout,    // pad enable, tristate lives outside
   input  usb_bus_pkg::bus_addr_t cwusb_addr,
   input  logic                   cwusb_rdn,
   input  logic                   cwusb_wrn,
   input  logic                   cwusb_cen,
   input  logic                   cwusb_alen,

   // byte stream in
   input  usb_bus_pkg::byte_t     stream_data,
   input  logic                   stream_strobe
);

   usb_bus_pkg::bus_addr_t reg_address;
   usb_bus_pkg::bytecnt_t  reg_bytecnt;
   usb_bus_pkg::byte_t     reg_datao;
   usb_bus_pkg::byte_t     reg_datai;
   logic                   reg_read;
   logic                   reg_write;
   logic                   fast_fifo_read;
   usb_bus_pkg::word_t     ctrl_word;
   usb_bus_pkg::byte_t     fifo_byte;

   ////////////////////////////////////////////////////////////
   // bridge
   ////////////////////////////////////////////////////////////

   usb_reg_main u_main (
      .clk_usb        (clk_usb),
      .reset          (reset),
      .cwusb_din      (cwusb_din),
      .cwusb_dout     (cwusb_dout),
      .cwusb_isout    (cwusb_isout),
      .cwusb_addr     (cwusb_addr),
      .cwusb_rdn      (cwusb_rdn),
      .cwusb_wrn      (cwusb_wrn),
      .cwusb_cen      (cwusb_cen),
      .cwusb_alen     (cwusb_alen),
      .fast_fifo_read (fast_fifo_read),
      .reg_address    (reg_address),
      .reg_bytecnt    (reg_bytecnt),
      .reg_datao      (reg_datao),
      .reg_datai      (reg_datai),
      .reg_read       (reg_read),
      .reg_write      (reg_write)
   );

   ////////////////////////////////////////////////////////////
   // register blocks and read mux
   ////////////////////////////////////////////////////////////

   reg_control u_control (
      .clk_usb        (clk_usb),
      .reset          (reset),
      .reg_address    (reg_address),
      .reg_bytecnt    (reg_bytecnt),
      .reg_datao      (reg_datao),
      .reg_write      (reg_write),
      .ctrl_word      (ctrl_word),
      .fast_fifo_read (fast_fifo_read)   // loops back to the bridge
   );

   reg_fifo u_fifo (
      .clk_usb        (clk_usb),
      .reset          (reset),
      .stream_data    (stream_data),
      .stream_strobe  (stream_strobe),
      .reg_address    (reg_address),
      .reg_read       (reg_read),
      .fifo_byte      (fifo_byte)
   );

   reg_read_mux u_mux (
      .reg_address    (reg_address),
      .reg_bytecnt    (reg_bytecnt),
      .ctrl_word      (ctrl_word),
      .fifo_byte      (fifo_byte),
      .reg_datai      (reg_datai)
   );

endmodule

//--- usb_reg_top.f
logic/usb_bus_pkg.sv
logic/reg_map_pkg.sv
logic/usb_reg_main.sv
logic/reg_control.sv
logic/reg_fifo.sv
logic/reg_read_mux.sv
logic/usb_reg_top.sv
bench/tb_clock.sv
bench/usb_reg_tb.sv
